// File: Makefile
# Verilator build and run for the modular multiplier testbench

VERILATOR ?= verilator
TOP       ?= tb_mod_mult_top
FILELIST  ?= mod_mult_top.f
BUILD_DIR ?= obj_dir
SIM       ?= sim_$(TOP)
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR SIM VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(SIM)
	@out="$$(./$(BUILD_DIR)/$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: common/poly_mult_pkg.sv
/*
  Shared constants for the redundant polynomial modular multiplier.
  Holds default sizes, the opcode enum, fixed latencies and size helpers.
*/
package poly_mult_pkg;

  // Default operand shape
  parameter int DEF_WORD_BITS       = 16; // Radix bits per coefficient
  parameter int DEF_NUM_WORDS       = 4;  // Words in the modulus
  parameter int DEF_REDUN_WORD_BITS = 1;  // Headroom bits per coefficient
  parameter int DEF_REDUCTION_BITS  = 8;  // Index bits per reduction table

  // Largest 64-bit prime, odd as required
  parameter logic [DEF_NUM_WORDS*DEF_WORD_BITS-1:0] DEF_MODULUS = 64'hFFFF_FFFF_FFFF_FFC5;

  // Operation select
  typedef enum logic {
    OP_MULTIPLY = 1'b0, // A*B, or A*A in square mode
    OP_REDUCE   = 1'b1  // Operand A straight into the reduction half
  } op_e;

  // Fixed depths from i_val to o_val
  parameter int MULT_LATENCY   = 7;
  parameter int REDUCE_LATENCY = 3;

  // Bits above the modulus width that still need a table lookup.
  // Columns come out of the grid at WORD_BITS spacing, each one up to
  // COEF_BITS wide after the first carry level
  function automatic int calc_hi_bits(input int word_bits, input int num_words,
                                      input int redun_bits);
    int coef_bits;
    int splits;
    int num_cols;
    coef_bits = word_bits + redun_bits;
    splits    = (2*coef_bits + word_bits - 1) / word_bits; // Slices per product
    num_cols  = 2*num_words + splits;                      // 2*(I_WORD-1) + splits
    return (num_cols - num_words)*word_bits + redun_bits + 1;
  endfunction

  // Number of tables needed to cover the overflow bits
  function automatic int calc_reduction_cnt(input int word_bits, input int num_words,
                                            input int redun_bits, input int red_bits);
    int hi_bits;
    hi_bits = calc_hi_bits(word_bits, num_words, redun_bits);
    return (hi_bits + red_bits - 1) / red_bits;
  endfunction

endpackage

// File: hdl/mod_mult_top.sv
/*
  Modular multiplier top level.
  Sets the sizes and ties the pipeline to its reduction tables.
*/
`timescale 1ns/1ps

module mod_mult_top
  import poly_mult_pkg::*;
#(
  parameter bit                             SQ_MODE         = 0,
  parameter int                             WORD_BITS       = DEF_WORD_BITS,
  parameter int                             NUM_WORDS       = DEF_NUM_WORDS,
  parameter int                             REDUN_WORD_BITS = DEF_REDUN_WORD_BITS,
  parameter int                             REDUCTION_BITS  = DEF_REDUCTION_BITS,
  parameter logic [NUM_WORDS*WORD_BITS-1:0] MODULUS         = DEF_MODULUS,
  // Derived
  parameter int I_WORD        = NUM_WORDS + 1,
  parameter int COEF_BITS     = WORD_BITS + REDUN_WORD_BITS,
  parameter int REDUCTION_CNT = calc_reduction_cnt(WORD_BITS, NUM_WORDS,
                                                   REDUN_WORD_BITS, REDUCTION_BITS)
) (
  input  logic                             i_clk,
  input  logic                             i_rst,
  input  logic                             i_val,
  input  op_e                              i_op,
  input  logic [I_WORD-1:0][COEF_BITS-1:0] i_dat_a,
  input  logic [I_WORD-1:0][COEF_BITS-1:0] i_dat_b,
  output logic [I_WORD-1:0][COEF_BITS-1:0] o_dat,
  output logic                             o_val
);

  logic [REDUCTION_CNT-1:0][REDUCTION_BITS-1:0]      chunk;   // Overflow indices
  logic [REDUCTION_CNT-1:0][NUM_WORDS*WORD_BITS-1:0] residue; // Looked-up residues

  poly_mod_mult #(
    .SQ_MODE         ( SQ_MODE         ),
    .WORD_BITS       ( WORD_BITS       ),
    .NUM_WORDS       ( NUM_WORDS       ),
    .MODULUS         ( MODULUS         ),
    .REDUCTION_BITS  ( REDUCTION_BITS  ),
    .REDUN_WORD_BITS ( REDUN_WORD_BITS )
  ) u_poly_mod_mult (
    .i_clk     ( i_clk   ),
    .i_rst     ( i_rst   ),
    .i_val     ( i_val   ),
    .i_op      ( i_op    ),
    .i_dat_a   ( i_dat_a ),
    .i_dat_b   ( i_dat_b ),
    .o_chunk   ( chunk   ),
    .i_residue ( residue ),
    .o_dat     ( o_dat   ),
    .o_val     ( o_val   )
  );

  reduction_table #(
    .WORD_BITS       ( WORD_BITS       ),
    .NUM_WORDS       ( NUM_WORDS       ),
    .REDUN_WORD_BITS ( REDUN_WORD_BITS ),
    .MODULUS         ( MODULUS         ),
    .REDUCTION_BITS  ( REDUCTION_BITS  )
  ) u_reduction_table (
    .i_chunk   ( chunk   ),
    .o_residue ( residue )
  );

endmodule

// File: hdl/multiplier.sv
/*
  Registered unsigned multiplier for one grid element of the product array.
  Sized so a single element maps onto one DSP block.
*/
`timescale 1ns/1ps

module multiplier #(
  parameter int IN_BITS = 17 // Coefficient width
) (
  input  logic                   i_clk,
  input  logic [IN_BITS-1:0]     i_dat_a,
  input  logic [IN_BITS-1:0]     i_dat_b,
  output logic [2*IN_BITS-1:0]   o_dat    // Full width product one cycle later
);

  // Product register
  always_ff @(posedge i_clk) begin
    o_dat <= i_dat_a * i_dat_b; // Unsigned product of equal widths
  end

endmodule

// File: hdl/tree_adder.sv
/*
  Balanced adder tree over NUM_IN operands with a registered sum.
  Output grows by clog2(NUM_IN) bits so no carry is lost.
*/
`timescale 1ns/1ps

module tree_adder #(
  parameter int NUM_IN  = 2,
  parameter int IN_BITS = 16,
  // Derived
  parameter int OUT_BITS = IN_BITS + $clog2(NUM_IN)
) (
  input  logic                             i_clk,
  input  logic [NUM_IN-1:0][IN_BITS-1:0]   i_dat,
  output logic [OUT_BITS-1:0]              o_dat
);

  logic [OUT_BITS-1:0] sum; // Combinational tree result

  // Pairwise levels, each level halves the operand count
  always_comb begin
    logic [OUT_BITS-1:0] work [NUM_IN];
    int cnt;
    for (int i = 0; i < NUM_IN; i++) begin
      work[i] = OUT_BITS'(i_dat[i]); // Zero extend to final width
    end
    cnt = NUM_IN;
    for (int lvl = 0; lvl < $clog2(NUM_IN); lvl++) begin
      for (int i = 0; i < cnt/2; i++) begin
        work[i] = work[2*i] + work[2*i+1]; // Slots below i already consumed
      end
      if (cnt % 2 == 1) work[cnt/2] = work[cnt-1]; // Odd one rides up a level
      cnt = (cnt + 1) / 2;
    end
    sum = work[0];
  end

  always_ff @(posedge i_clk) begin
    o_dat <= sum;
  end

endmodule

// File: mod_mult_top.f
common/poly_mult_pkg.sv
hdl/multiplier.sv
hdl/tree_adder.sv
poly_mod_mult/reduction_table.sv
poly_mod_mult/poly_mod_mult.sv
hdl/mod_mult_top.sv
verif/tb_mod_mult_top.sv

// File: poly_mod_mult/poly_mod_mult.sv
/*
  Pipelined modular multiplier on redundant polynomial operands.
  Grid multiply, column sums and one carry, then table reduction and a final carry.
*/
`timescale 1ns/1ps

module poly_mod_mult
  import poly_mult_pkg::*;
#(
  parameter bit                             SQ_MODE         = 0, // Square i_dat_a only
  parameter int                             WORD_BITS       = 16,
  parameter int                             NUM_WORDS       = 4,
  parameter logic [NUM_WORDS*WORD_BITS-1:0] MODULUS         = '1,
  parameter int                             REDUCTION_BITS  = 8,
  parameter int                             REDUN_WORD_BITS = 1,
  // Derived
  parameter int I_WORD        = NUM_WORDS + 1,             // Extra word for overflow
  parameter int COEF_BITS     = WORD_BITS + REDUN_WORD_BITS,
  parameter int REDUCTION_CNT = calc_reduction_cnt(WORD_BITS, NUM_WORDS,
                                                   REDUN_WORD_BITS, REDUCTION_BITS)
) (
  input  logic                                              i_clk,
  input  logic                                              i_rst,
  input  logic                                              i_val,
  input  op_e                                               i_op,
  input  logic [I_WORD-1:0][COEF_BITS-1:0]                  i_dat_a,
  input  logic [I_WORD-1:0][COEF_BITS-1:0]                  i_dat_b,
  output logic [REDUCTION_CNT-1:0][REDUCTION_BITS-1:0]      o_chunk,   // Table indices
  input  logic [REDUCTION_CNT-1:0][NUM_WORDS*WORD_BITS-1:0] i_residue, // Table results
  output logic [I_WORD-1:0][COEF_BITS-1:0]                  o_dat,
  output logic                                              o_val
);

  localparam int MULT_SPLITS = (2*COEF_BITS + WORD_BITS - 1) / WORD_BITS; // Slices per product
  localparam int NUM_COLS    = 2*(I_WORD-1) + MULT_SPLITS;
  localparam int SLICE_BITS  = WORD_BITS + (SQ_MODE ? 1 : 0);  // Room for doubling
  localparam int ACC_IN      = MULT_SPLITS*I_WORD;             // Max slices in a column
  localparam int ACC_BITS    = SLICE_BITS + $clog2(ACC_IN);
  localparam int RED_IN      = REDUCTION_CNT + 2;              // Residues, low word, carry
  localparam int RED_BITS    = WORD_BITS + $clog2(RED_IN);
  localparam int PIPES       = MULT_LATENCY - 1;

  logic [PIPES:0] val;    // Valid shift register
  logic           reduce_now;

  logic [I_WORD-1:0][COEF_BITS-1:0]          dat_a, dat_b;
  logic [I_WORD*I_WORD-1:0][2*COEF_BITS-1:0] mul_out;
  logic [NUM_COLS-1:0][ACC_BITS-1:0]         acc_sum;   // Column sums
  logic [NUM_COLS-1:0][WORD_BITS:0]          col_mul;   // After first carry
  logic [NUM_COLS-1:0][COEF_BITS-1:0]        col_sel;   // Multiply or reduce source
  logic [REDUCTION_CNT*REDUCTION_BITS-1:0]   hi;        // Bits above modulus width

  logic [NUM_WORDS-1:0][WORD_BITS-1:0]       lo_r;      // Low words, address stage
  logic [NUM_WORDS-1:1][REDUN_WORD_BITS-1:0] lo_c_r;    // Headroom of word below
  logic [REDUCTION_CNT-1:0][REDUCTION_BITS-1:0] chunk_r;
  logic [NUM_WORDS-1:0][RED_BITS-1:0]        red_sum;   // Per-word reduction sums

  assign reduce_now = i_val && (i_op == OP_REDUCE);
  assign o_val      = val[PIPES];
  assign o_chunk    = chunk_r;

  // Valid tracking, reduce issue flushes anything in flight
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val <= '0;
    end else if (reduce_now) begin
      val <= '0;
      val[MULT_LATENCY-REDUCE_LATENCY] <= 1'b1; // Lands on o_val 3 cycles on
    end else begin
      val <= {val[PIPES-1:0], i_val};
    end
  end

  // Stage 1 operand register
  always_ff @(posedge i_clk) begin
    dat_a <= i_dat_a;
    dat_b <= SQ_MODE ? i_dat_a : i_dat_b;
  end

  // Stage 2 coefficient grid, upper triangle only when squaring
  for (genvar x = 0; x < I_WORD; x++) begin : g_mul_x
    for (genvar y = 0; y < I_WORD; y++) begin : g_mul_y
      if (!SQ_MODE || x >= y) begin : g_used
        multiplier #(
          .IN_BITS ( COEF_BITS )
        ) u_multiplier (
          .i_clk   ( i_clk                  ),
          .i_dat_a ( dat_a[x]               ),
          .i_dat_b ( dat_b[y]               ),
          .o_dat   ( mul_out[x*I_WORD + y]  )
        );
      end else begin : g_unused
        assign mul_out[x*I_WORD + y] = '0; // Mirror of a doubled term
      end
    end
  end

  // Walk the grid and pick every product slice landing in column col
  function automatic logic [ACC_IN-1:0][SLICE_BITS-1:0] get_column(
    input int col,
    input logic [I_WORD*I_WORD-1:0][2*COEF_BITS-1:0] prods
  );
    int                     n;
    logic [2*COEF_BITS-1:0] part;
    logic [SLICE_BITS-1:0]  slice;
    get_column = '0;
    n = 0;
    for (int x = 0; x < I_WORD; x++) begin
      for (int y = 0; y < I_WORD; y++) begin
        if (!SQ_MODE || x >= y) begin
          for (int s = 0; s < MULT_SPLITS; s++) begin
            if (x + y + s == col) begin
              part  = prods[x*I_WORD + y] >> (s*WORD_BITS);
              slice = SLICE_BITS'(part[WORD_BITS-1:0]);
              if (SQ_MODE && x > y) slice = slice << 1; // Off-diagonal counts twice
              get_column[n] = slice;
              n++;
            end
          end
        end
      end
    end
  endfunction

  // Stage 3 column sums, stage 4 one carry level into the next column
  for (genvar k = 0; k < NUM_COLS; k++) begin : g_col
    logic [ACC_IN-1:0][SLICE_BITS-1:0] acc_in;
    logic [1:0][WORD_BITS-1:0]         c0_in;

    always_comb acc_in = get_column(k, mul_out);

    tree_adder #(
      .NUM_IN  ( ACC_IN     ),
      .IN_BITS ( SLICE_BITS )
    ) u_col_sum (
      .i_clk ( i_clk      ),
      .i_dat ( acc_in     ),
      .o_dat ( acc_sum[k] )
    );

    always_comb begin
      c0_in[0] = acc_sum[k][WORD_BITS-1:0];
      if (k == 0) c0_in[1] = '0;
      else        c0_in[1] = WORD_BITS'(acc_sum[k-1][ACC_BITS-1:WORD_BITS]);
    end

    tree_adder #(
      .NUM_IN  ( 2         ),
      .IN_BITS ( WORD_BITS )
    ) u_carry0 (
      .i_clk ( i_clk      ),
      .i_dat ( c0_in      ),
      .o_dat ( col_mul[k] )
    );
  end

  // Reduce-only ops replace the column data at the address stage
  always_comb begin
    for (int c = 0; c < NUM_COLS; c++) begin
      col_sel[c] = COEF_BITS'(col_mul[c]);
      if (reduce_now) begin
        col_sel[c] = '0;
        if (c < I_WORD) col_sel[c] = i_dat_a[c];
      end
    end
    // Fold everything at or above 2^(NUM_WORDS*WORD_BITS) into one value
    hi = (REDUCTION_CNT*REDUCTION_BITS)'(col_sel[NUM_WORDS-1] >> WORD_BITS);
    for (int c = NUM_WORDS; c < NUM_COLS; c++) begin
      hi = hi + ((REDUCTION_CNT*REDUCTION_BITS)'(col_sel[c]) << ((c-NUM_WORDS)*WORD_BITS));
    end
  end

  // Stage 5 address register
  always_ff @(posedge i_clk) begin
    for (int i = 0; i < NUM_WORDS; i++) begin
      lo_r[i] <= col_sel[i][WORD_BITS-1:0];
    end
    for (int i = 1; i < NUM_WORDS; i++) begin
      lo_c_r[i] <= col_sel[i-1][COEF_BITS-1:WORD_BITS]; // Sits inside word i
    end
    chunk_r <= hi;
  end

  // Stage 6 per-word sum of low word and residue slices
  for (genvar i = 0; i < NUM_WORDS; i++) begin : g_red
    logic [RED_IN-1:0][WORD_BITS-1:0] red_in;
    logic [1:0][WORD_BITS-1:0]        c1_in;
    logic [WORD_BITS:0]               c1_out;

    always_comb begin
      red_in[0] = lo_r[i];
      if (i == 0) red_in[1] = '0;
      else        red_in[1] = WORD_BITS'(lo_c_r[i]);
      for (int p = 0; p < REDUCTION_CNT; p++) begin
        red_in[2+p] = i_residue[p][i*WORD_BITS +: WORD_BITS];
      end
    end

    tree_adder #(
      .NUM_IN  ( RED_IN    ),
      .IN_BITS ( WORD_BITS )
    ) u_red_sum (
      .i_clk ( i_clk      ),
      .i_dat ( red_in     ),
      .o_dat ( red_sum[i] )
    );

    // Stage 7 final carry
    always_comb begin
      c1_in[0] = red_sum[i][WORD_BITS-1:0];
      if (i == 0) c1_in[1] = '0;
      else        c1_in[1] = WORD_BITS'(red_sum[i-1][RED_BITS-1:WORD_BITS]);
    end

    tree_adder #(
      .NUM_IN  ( 2         ),
      .IN_BITS ( WORD_BITS )
    ) u_carry1 (
      .i_clk ( i_clk  ),
      .i_dat ( c1_in  ),
      .o_dat ( c1_out )
    );

    assign o_dat[i] = COEF_BITS'(c1_out);
  end

  // Top carry becomes the extra coefficient, delayed to line up with the rest
  logic [RED_BITS-WORD_BITS-1:0] top_carry;

  tree_adder #(
    .NUM_IN  ( 1                    ),
    .IN_BITS ( RED_BITS - WORD_BITS )
  ) u_top_carry (
    .i_clk ( i_clk                                    ),
    .i_dat ( red_sum[NUM_WORDS-1][RED_BITS-1:WORD_BITS] ),
    .o_dat ( top_carry                                )
  );

  assign o_dat[NUM_WORDS] = COEF_BITS'(top_carry);

endmodule

// File: poly_mod_mult/reduction_table.sv
/*
  Reduction tables, one per overflow chunk position, built at elaboration.
  Entry k of table p holds k*2^(modulus width + p*REDUCTION_BITS) mod MODULUS.
*/
`timescale 1ns/1ps

module reduction_table
  import poly_mult_pkg::*;
#(
  parameter int                                WORD_BITS       = 16,
  parameter int                                NUM_WORDS       = 4,
  parameter int                                REDUN_WORD_BITS = 1,
  parameter logic [NUM_WORDS*WORD_BITS-1:0]    MODULUS         = '1,
  parameter int                                REDUCTION_BITS  = 8,
  // Derived
  parameter int REDUCTION_CNT = calc_reduction_cnt(WORD_BITS, NUM_WORDS,
                                                   REDUN_WORD_BITS, REDUCTION_BITS)
) (
  input  logic [REDUCTION_CNT-1:0][REDUCTION_BITS-1:0]        i_chunk,
  output logic [REDUCTION_CNT-1:0][NUM_WORDS*WORD_BITS-1:0]   o_residue
);

  localparam int MOD_BITS = NUM_WORDS*WORD_BITS;
  localparam int ENTRIES  = 2**REDUCTION_BITS;

  // Table for one chunk position
  function automatic logic [ENTRIES-1:0][MOD_BITS-1:0] build_table(input int pos);
    logic [MOD_BITS:0]                      base; // One spare bit for the doubling
    logic [MOD_BITS:0]                      acc;
    logic [ENTRIES-1:0][MOD_BITS-1:0]       tbl;
    base = 1;
    for (int i = 0; i < MOD_BITS + pos*REDUCTION_BITS; i++) begin
      base = base << 1;                        // Repeated doubling mod M
      if (base >= MODULUS) base = base - MODULUS;
    end
    acc = '0;
    for (int k = 0; k < ENTRIES; k++) begin
      tbl[k] = acc[MOD_BITS-1:0];              // k*base mod M
      acc = acc + base;
      if (acc >= MODULUS) acc = acc - MODULUS;
    end
    return tbl;
  endfunction

  for (genvar p = 0; p < REDUCTION_CNT; p++) begin : g_table
    localparam logic [ENTRIES-1:0][MOD_BITS-1:0] TABLE = build_table(p);
    assign o_residue[p] = TABLE[i_chunk[p]]; // Plain lookup, same cycle
  end

endmodule

// File: verif/tb_mod_mult_top.sv
/*
  Testbench for the redundant polynomial modular multiplier.
  Random operands from a fixed seed, checked against a big-integer model.
*/
`timescale 1ns/1ps

module tb_mod_mult_top
  import poly_mult_pkg::*;
();

  localparam int WORD_BITS = DEF_WORD_BITS;
  localparam int NUM_WORDS = DEF_NUM_WORDS;
  localparam int I_WORD    = NUM_WORDS + 1;                       // Extra overflow word
  localparam int COEF_BITS = WORD_BITS + DEF_REDUN_WORD_BITS;
  localparam int MOD_BITS  = NUM_WORDS*WORD_BITS;
  localparam int WIDE_BITS = 256;                                 // Holds any product

  typedef logic [I_WORD-1:0][COEF_BITS-1:0] operand_t;
  typedef logic [COEF_BITS-1:0]             coef_t;
  typedef logic [MOD_BITS-1:0]              mod_t;
  typedef logic [WIDE_BITS-1:0]             wide_t;

  // One outstanding result
  typedef struct packed {
    logic [31:0] due; // Edge after which o_val must be high
    mod_t        res; // Expected residue
  } expect_t;

  localparam wide_t MOD_WIDE = wide_t'(DEF_MODULUS);

  logic        i_clk    = 1'b0;
  logic        i_rst;
  logic        i_val;
  op_e         i_op;
  operand_t    i_dat_a;
  operand_t    i_dat_b;
  operand_t    o_dat;
  logic        o_val;

  logic [31:0] edge_cnt = '0;   // Rising edges so far
  logic        mon_en   = 1'b0; // Output monitor armed after first reset
  expect_t     exp_q[$];        // Results in flight with the oldest first

  mod_mult_top #(
    .SQ_MODE ( 1'b0 )
  ) uut (
    .i_clk   ( i_clk   ),
    .i_rst   ( i_rst   ),
    .i_val   ( i_val   ),
    .i_op    ( i_op    ),
    .i_dat_a ( i_dat_a ),
    .i_dat_b ( i_dat_b ),
    .o_dat   ( o_dat   ),
    .o_val   ( o_val   )
  );

  initial begin
    forever #2 i_clk = ~i_clk; // 4 ns period
  end

  always @(posedge i_clk) edge_cnt <= edge_cnt + 1;

  // Redundant form to integer with coefficients spaced WORD_BITS apart
  function automatic wide_t to_int(input operand_t v);
    wide_t acc;
    acc = '0;
    for (int i = 0; i < I_WORD; i++) begin
      acc = acc + (wide_t'(v[i]) << (i*WORD_BITS));
    end
    return acc;
  endfunction

  function automatic mod_t mod_of(input wide_t v);
    return mod_t'(v % MOD_WIDE);
  endfunction

  // Value below MODULUS with the top coefficient zero
  function automatic operand_t rand_reduced();
    wide_t    r;
    operand_t v;
    v = '0;
    r = wide_t'({$urandom, $urandom}) % MOD_WIDE;
    for (int i = 0; i < NUM_WORDS; i++) begin
      v[i] = coef_t'(r[i*WORD_BITS +: WORD_BITS]);
    end
    return v;
  endfunction

  // Every coefficient uses the full headroom
  function automatic operand_t rand_redundant();
    operand_t v;
    for (int i = 0; i < I_WORD; i++) begin
      v[i] = coef_t'($urandom);
    end
    return v;
  endfunction

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at %0d ns: %s", $time, msg);
    abort_run();
  endtask

  task automatic check_value(input string name, input mod_t exp_v, input mod_t act_v);
    if (act_v !== exp_v) begin
      $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, exp_v, act_v);
      abort_run();
    end
  endtask

  // Coefficient must be fully known
  task automatic check_coef(input string name, input coef_t act_v);
    if ($isunknown(act_v)) begin
      $display("FAILED at %0d ns: %s expected known bits, got %h", $time, name, act_v);
      abort_run();
    end
  endtask

  // Flush model entries that would land after edge n
  task automatic drop_after(input logic [31:0] n);
    while (exp_q.size() > 0 && exp_q[$].due > n) begin
      void'(exp_q.pop_back());
    end
  endtask

  task automatic issue(input op_e op, input operand_t a, input operand_t b, input mod_t res);
    expect_t e;
    @(posedge i_clk);
    i_val   <= 1'b1;
    i_op    <= op;
    i_dat_a <= a;
    i_dat_b <= b;
    if (op == OP_REDUCE) drop_after(edge_cnt + 1); // Reduce clears the pipe
    e.due = edge_cnt + 1 + ((op == OP_REDUCE) ? REDUCE_LATENCY : MULT_LATENCY);
    e.res = res;
    exp_q.push_back(e);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge i_clk);
      i_val <= 1'b0;
    end
  endtask

  // Wait until every queued result is seen
  task automatic drain(input int limit);
    int n;
    n = 0;
    @(posedge i_clk);
    i_val <= 1'b0;
    while (exp_q.size() != 0 && n < limit) begin
      @(posedge i_clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      report_error($sformatf("%0d results still missing after %0d cycles", exp_q.size(), limit));
    end
  endtask

  task automatic wait_output(output operand_t d);
    int   n;
    logic got;
    n   = 0;
    got = 1'b0;
    d   = '0;
    @(posedge i_clk);
    i_val <= 1'b0;
    while (!got && n < 20) begin
      @(negedge i_clk); // Mid-cycle where outputs have settled
      if (o_val === 1'b1) begin
        d   = o_dat;
        got = 1'b1;
      end
      n++;
    end
    if (!got) report_error("no o_val within 20 cycles for a chained square");
  endtask

  task automatic apply_reset(input int cycles);
    @(posedge i_clk);
    i_rst <= 1'b1;
    i_val <= 1'b0;
    drop_after(edge_cnt + 1); // Everything not yet out is lost
    repeat (cycles) @(posedge i_clk);
    i_rst <= 1'b0;
  endtask

  // Every output strobe must match the oldest due result
  always @(negedge i_clk) begin
    if (mon_en) begin
      if ($isunknown(o_val)) begin
        report_error("o_val is unknown");
      end else if (o_val) begin
        if (exp_q.size() == 0) begin
          report_error("o_val strobe with no result due");
        end else if (exp_q[0].due != edge_cnt) begin
          report_error($sformatf("o_val strobe after edge %0d, next result due after edge %0d",
                                 edge_cnt, exp_q[0].due));
        end else begin
          for (int i = 0; i < I_WORD; i++) begin
            check_coef($sformatf("o_dat[%0d]", i), o_dat[i]);
          end
          check_value("o_dat mod MODULUS", exp_q[0].res, mod_of(to_int(o_dat)));
          void'(exp_q.pop_front());
        end
      end else if (exp_q.size() != 0 && exp_q[0].due <= edge_cnt) begin
        report_error($sformatf("result due after edge %0d never arrived", exp_q[0].due));
      end
    end
  end

  initial begin
    operand_t    a;
    operand_t    b;
    operand_t    d;
    mod_t        x;
    int unsigned r;
    void'($urandom(6));
    i_rst   = 1'b1;
    i_val   = 1'b0;
    i_op    = OP_MULTIPLY;
    i_dat_a = '0;
    i_dat_b = '0;
    repeat (10) @(posedge i_clk);
    i_rst  <= 1'b0;
    mon_en <= 1'b1;

    idle(20); // Quiet after reset

    // Reduced operands one at a time
    repeat (20) begin
      a = rand_reduced();
      b = rand_reduced();
      issue(OP_MULTIPLY, a, b, mod_of(to_int(a) * to_int(b)));
      drain(20);
    end

    // Full headroom operands back to back
    repeat (20) begin
      a = rand_redundant();
      b = rand_redundant();
      issue(OP_MULTIPLY, a, b, mod_of(to_int(a) * to_int(b)));
    end
    drain(20);

    // Reduce only
    repeat (20) begin
      a = rand_redundant();
      issue(OP_REDUCE, a, '0, mod_of(to_int(a)));
      drain(20);
    end

    // Output fed back as both operands
    d = rand_reduced();
    x = mod_of(to_int(d));
    repeat (20) begin
      x = mod_of(wide_t'(x) * wide_t'(x)); // Model square
      issue(OP_MULTIPLY, d, d, x);
      wait_output(d);
    end
    drain(20);

    // Issue every cycle with a reduce now and then
    for (int cyc = 0; cyc < 200; cyc++) begin
      r = $urandom % 8;
      a = rand_redundant();
      b = rand_redundant();
      if (r == 0) issue(OP_REDUCE, a, '0, mod_of(to_int(a)));
      else if (r == 1) idle(1);
      else issue(OP_MULTIPLY, a, b, mod_of(to_int(a) * to_int(b)));
    end
    drain(30);

    // Reset in the middle of a burst
    repeat (6) begin
      a = rand_redundant();
      b = rand_redundant();
      issue(OP_MULTIPLY, a, b, mod_of(to_int(a) * to_int(b)));
    end
    apply_reset(3);
    drain(20);
    idle(20);

    $display("Test completed successfully");
    $finish;
  end

endmodule
